//--- dllp_builder.sv
`timescale 1ns/1ps
`include "dllp_macros.svh"

module dllp_builder (
    input  logic                 sclk,
    input  logic                 arst_n_i,
    input  logic                 issue_i,
    input  dllp_pkg::dllp_type_e issue_type_i,
    fc_credit_if.dst             credit_if,
    input  dllp_pkg::seq_num_t   next_rcv_seq_i,
    output logic                 body_valid_o,
    output dllp_pkg::dllp_body_t body_o
);

    dllp_pkg::fc_hdr_t    hdr_fc;
    dllp_pkg::fc_data_t   data_fc;
    dllp_pkg::dllp_body_t body_next;

    // Credit source: limits for InitFC, TL values for UpdateFC
    always_comb begin
        hdr_fc  = '0;
        data_fc = '0;
        case (issue_type_i)
            dllp_pkg::INITFC1_P, dllp_pkg::INITFC2_P: begin
                hdr_fc  = dllp_pkg::fc_hdr_t'(`CL_P_HDR);
                data_fc = dllp_pkg::fc_data_t'(`CL_P_DATA);
            end
            dllp_pkg::INITFC1_NP, dllp_pkg::INITFC2_NP: begin
                hdr_fc  = dllp_pkg::fc_hdr_t'(`CL_NP_HDR);
                data_fc = dllp_pkg::fc_data_t'(`CL_NP_DATA);
            end
            dllp_pkg::INITFC1_CPL, dllp_pkg::INITFC2_CPL: begin
                hdr_fc  = dllp_pkg::fc_hdr_t'(`CL_CPL_HDR);
                data_fc = dllp_pkg::fc_data_t'(`CL_CPL_DATA);
            end
            dllp_pkg::UPDATEFC_P: begin
                hdr_fc  = credit_if.p_hdr;
                data_fc = credit_if.p_data;
            end
            dllp_pkg::UPDATEFC_NP: begin
                hdr_fc  = credit_if.np_hdr;
                data_fc = credit_if.np_data;
            end
            dllp_pkg::UPDATEFC_CPL: begin
                hdr_fc  = credit_if.cpl_hdr;
                data_fc = credit_if.cpl_data;
            end
            default: ;  // Ack/Nak carry no credits
        endcase

        if (issue_type_i == dllp_pkg::ACK || issue_type_i == dllp_pkg::NAK)
            body_next = {issue_type_i, 12'd0, next_rcv_seq_i};
        else
            body_next = {issue_type_i, 2'b00, hdr_fc, 2'b00, data_fc};     // Scales stay 0
    end

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i)
            body_valid_o <= 1'b0;
        else
            body_valid_o <= issue_i;
    end

    always_ff @(posedge sclk) begin
        if (issue_i)
            body_o <= body_next;
    end

    a_type_known : assert property (@(posedge sclk) disable iff (!arst_n_i)
        issue_i |-> !$isunknown(issue_type_i))
        else $error("Unknown DLLP type on issue");

endmodule

//--- dllp_crc16.sv
`timescale 1ns/1ps
`include "dllp_macros.svh"

module dllp_crc16 (
    input  logic                 sclk,
    input  logic                 arst_n_i,
    input  logic                 body_valid_i,
    input  dllp_pkg::dllp_body_t body_i,
    output logic                 crc_valid_o,
    output dllp_pkg::dllp_body_t crc_body_o,
    output dllp_pkg::dllp_crc_t  crc_o
);

    dllp_pkg::dllp_crc_t crc_calc;

    // Bit-serial CRC unrolled over the 32 body bits, MSB first
    always_comb begin
        crc_calc = `CRC_SEED;
        for (int i = 0; i < 32; i++) begin
            if (crc_calc[15] ^ body_i[31-i])
                crc_calc = {crc_calc[14:0], 1'b0} ^ `CRC_POLY;
            else
                crc_calc = {crc_calc[14:0], 1'b0};
        end
    end

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i)
            crc_valid_o <= 1'b0;
        else
            crc_valid_o <= body_valid_i;
    end

    always_ff @(posedge sclk) begin
        if (body_valid_i) begin
            crc_body_o <= body_i;
            crc_o      <= ~crc_calc;    // Transmitted inverted
        end
    end

endmodule

//--- dllp_framer.sv
`timescale 1ns/1ps
`include "dllp_macros.svh"

module dllp_framer (
    input  logic                 sclk,
    input  logic                 arst_n_i,
    input  logic                 crc_valid_i,
    input  dllp_pkg::dllp_body_t crc_body_i,
    input  dllp_pkg::dllp_crc_t  crc_i,
    output logic                 dllp_valid_o,
    output dllp_pkg::pipe_data_t dllp_data_o
);

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            dllp_valid_o <= 1'b0;
            dllp_data_o  <= '0;
        end else begin
            dllp_valid_o <= crc_valid_i;
            // SDP token, then body, then CRC; idle beats are all zero
            dllp_data_o  <= crc_valid_i ?
                {{(`PIPE_WIDTH-64){1'b0}}, crc_i, crc_body_i, `SDP_TOKEN} : '0;
        end
    end

    a_idle_zero : assert property (@(posedge sclk) disable iff (!arst_n_i)
        !dllp_valid_o |-> (dllp_data_o == '0))
        else $error("PIPE data not zero on idle beat");

endmodule

//--- dllp_gen_top.sv
`timescale 1ns/1ps

module dllp_gen_top (
    input  logic                  sclk,
    input  logic                  arst_n_i,
    input  dllp_pkg::link_state_e link_state_i,
    input  dllp_pkg::fc_hdr_t     cc_p_h_i,
    input  dllp_pkg::fc_hdr_t     cc_np_h_i,
    input  dllp_pkg::fc_hdr_t     cc_cpl_h_i,
    input  dllp_pkg::fc_data_t    cc_p_d_i,
    input  dllp_pkg::fc_data_t    cc_np_d_i,
    input  dllp_pkg::fc_data_t    cc_cpl_d_i,
    input  logic                  nak_scheduled_i,
    input  dllp_pkg::seq_num_t    next_rcv_seq_i,
    output logic                  init1_sent_o,
    output logic                  init2_sent_o,
    output logic                  dllp_valid_o,
    output dllp_pkg::pipe_data_t  dllp_data_o
);

    logic                 issue;
    dllp_pkg::dllp_type_e issue_type;
    logic                 body_valid;
    dllp_pkg::dllp_body_t body;
    logic                 crc_valid;
    dllp_pkg::dllp_body_t crc_body;
    dllp_pkg::dllp_crc_t  crc;

    fc_credit_if credit_if ();

    // Source side of the credit bundle
    assign credit_if.p_hdr    = cc_p_h_i;
    assign credit_if.np_hdr   = cc_np_h_i;
    assign credit_if.cpl_hdr  = cc_cpl_h_i;
    assign credit_if.p_data   = cc_p_d_i;
    assign credit_if.np_data  = cc_np_d_i;
    assign credit_if.cpl_data = cc_cpl_d_i;

    dllp_sched_ctrl sched_i (
        .sclk            (sclk),
        .arst_n_i        (arst_n_i),
        .link_state_i    (link_state_i),
        .nak_scheduled_i (nak_scheduled_i),
        .issue_o         (issue),
        .issue_type_o    (issue_type),
        .init1_sent_o    (init1_sent_o),
        .init2_sent_o    (init2_sent_o)
    );

    dllp_builder builder_i (
        .sclk           (sclk),
        .arst_n_i       (arst_n_i),
        .issue_i        (issue),
        .issue_type_i   (issue_type),
        .credit_if      (credit_if.dst),
        .next_rcv_seq_i (next_rcv_seq_i),
        .body_valid_o   (body_valid),
        .body_o         (body)
    );

    dllp_crc16 crc_i (
        .sclk         (sclk),
        .arst_n_i     (arst_n_i),
        .body_valid_i (body_valid),
        .body_i       (body),
        .crc_valid_o  (crc_valid),
        .crc_body_o   (crc_body),
        .crc_o        (crc)
    );

    dllp_framer framer_i (
        .sclk         (sclk),
        .arst_n_i     (arst_n_i),
        .crc_valid_i  (crc_valid),
        .crc_body_i   (crc_body),
        .crc_i        (crc),
        .dllp_valid_o (dllp_valid_o),
        .dllp_data_o  (dllp_data_o)
    );

endmodule

//--- dllp_macros.svh
`ifndef DLLP_MACROS_SVH
`define DLLP_MACROS_SVH

// PIPE and field widths
`define PIPE_WIDTH          256
`define FC_HDR_WIDTH        8
`define FC_DATA_WIDTH       12
`define SEQ_WIDTH           12

// Advertised credit limits for InitFC1/InitFC2
`define CL_P_HDR            4
`define CL_P_DATA           4
`define CL_NP_HDR           4
`define CL_NP_DATA          4
`define CL_CPL_HDR          4
`define CL_CPL_DATA         4

// Idle cycles between rounds, kept short for simulation
`define DLLP_RESEND_CYCLES  64

// SDP framing token
`define SDP_TOKEN           16'hACF0

// DLLP CRC-16
`define CRC_POLY            16'h100B
`define CRC_SEED            16'hFFFF

`endif

//--- dllp_pkg.sv
`include "dllp_macros.svh"

package dllp_pkg;

    typedef logic [`FC_HDR_WIDTH-1:0]  fc_hdr_t;
    typedef logic [`FC_DATA_WIDTH-1:0] fc_data_t;
    typedef logic [`SEQ_WIDTH-1:0]     seq_num_t;
    typedef logic [31:0]               dllp_body_t;
    typedef logic [15:0]               dllp_crc_t;
    typedef logic [`PIPE_WIDTH-1:0]    pipe_data_t;

    // Link state as reported by the DLCMSM
    typedef enum logic [1:0] {
        INACTIVE = 2'd0,
        INIT1    = 2'd1,
        INIT2    = 2'd2,
        ACTIVE   = 2'd3
    } link_state_e;

    // Values are the DLLP type bytes, VC0 only
    typedef enum logic [7:0] {
        ACK          = 8'h00,
        NAK          = 8'h10,
        INITFC1_P    = 8'h40,
        INITFC1_NP   = 8'h50,
        INITFC1_CPL  = 8'h60,
        UPDATEFC_P   = 8'h80,
        UPDATEFC_NP  = 8'h90,
        UPDATEFC_CPL = 8'hA0,
        INITFC2_P    = 8'hC0,
        INITFC2_NP   = 8'hD0,
        INITFC2_CPL  = 8'hE0
    } dllp_type_e;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT
    } sched_state_e;

endpackage

//--- dllp_sched_ctrl.sv
`timescale 1ns/1ps
`include "dllp_macros.svh"

module dllp_sched_ctrl (
    input  logic                  sclk,
    input  logic                  arst_n_i,
    input  dllp_pkg::link_state_e link_state_i,
    input  logic                  nak_scheduled_i,
    output logic                  issue_o,
    output dllp_pkg::dllp_type_e  issue_type_o,
    output logic                  init1_sent_o,
    output logic                  init2_sent_o
);

    localparam int CNT_W = $clog2(`DLLP_RESEND_CYCLES + 1);

    dllp_pkg::sched_state_e state_q;
    dllp_pkg::link_state_e  served_q;       // Link state this round belongs to
    logic [1:0]             idx_q;          // Position inside the round
    logic [CNT_W-1:0]       wait_cnt_q;
    logic                   state_change;
    logic                   last_in_round;

    assign state_change  = (link_state_i != served_q);
    assign issue_o       = (state_q == dllp_pkg::S_ISSUE) && !state_change;
    assign last_in_round = (served_q == dllp_pkg::ACTIVE) ? (idx_q == 2'd3) : (idx_q == 2'd2);

    // Type for the current slot of the round
    always_comb begin
        issue_type_o = dllp_pkg::ACK;
        case (served_q)
            dllp_pkg::INIT1: begin
                case (idx_q)
                    2'd0:    issue_type_o = dllp_pkg::INITFC1_P;
                    2'd1:    issue_type_o = dllp_pkg::INITFC1_NP;
                    default: issue_type_o = dllp_pkg::INITFC1_CPL;
                endcase
            end
            dllp_pkg::INIT2: begin
                case (idx_q)
                    2'd0:    issue_type_o = dllp_pkg::INITFC2_P;
                    2'd1:    issue_type_o = dllp_pkg::INITFC2_NP;
                    default: issue_type_o = dllp_pkg::INITFC2_CPL;
                endcase
            end
            dllp_pkg::ACTIVE: begin
                case (idx_q)
                    2'd0:    issue_type_o = dllp_pkg::UPDATEFC_P;
                    2'd1:    issue_type_o = dllp_pkg::UPDATEFC_NP;
                    2'd2:    issue_type_o = dllp_pkg::UPDATEFC_CPL;
                    default: issue_type_o = nak_scheduled_i ? dllp_pkg::NAK : dllp_pkg::ACK;
                endcase
            end
            default: issue_type_o = dllp_pkg::ACK;
        endcase
    end

    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= dllp_pkg::S_IDLE;
            served_q   <= dllp_pkg::INACTIVE;
            idx_q      <= 2'd0;
            wait_cnt_q <= '0;
        end else begin
            case (state_q)
                dllp_pkg::S_IDLE: begin
                    if (link_state_i != dllp_pkg::INACTIVE) begin
                        served_q <= link_state_i;
                        idx_q    <= 2'd0;
                        state_q  <= dllp_pkg::S_ISSUE;
                    end
                end
                dllp_pkg::S_ISSUE: begin
                    if (state_change) begin
                        state_q <= dllp_pkg::S_IDLE;    // Items in flight still drain
                    end else if (last_in_round) begin
                        idx_q      <= 2'd0;
                        wait_cnt_q <= '0;
                        state_q    <= dllp_pkg::S_WAIT;
                    end else begin
                        idx_q <= idx_q + 2'd1;
                    end
                end
                dllp_pkg::S_WAIT: begin
                    if (state_change) begin
                        state_q <= dllp_pkg::S_IDLE;
                    end else if (wait_cnt_q == CNT_W'(`DLLP_RESEND_CYCLES - 1)) begin
                        state_q <= dllp_pkg::S_ISSUE;
                    end else begin
                        wait_cnt_q <= wait_cnt_q + 1'b1;
                    end
                end
                default: state_q <= dllp_pkg::S_IDLE;
            endcase
        end
    end

    // Flags rise after the first CPL of their init stage and drop when it ends
    always_ff @(posedge sclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            init1_sent_o <= 1'b0;
            init2_sent_o <= 1'b0;
        end else begin
            if (link_state_i != dllp_pkg::INIT1)
                init1_sent_o <= 1'b0;
            else if (issue_o && issue_type_o == dllp_pkg::INITFC1_CPL)
                init1_sent_o <= 1'b1;

            if (link_state_i != dllp_pkg::INIT2)
                init2_sent_o <= 1'b0;
            else if (issue_o && issue_type_o == dllp_pkg::INITFC2_CPL)
                init2_sent_o <= 1'b1;
        end
    end

    a_no_issue_inactive : assert property (@(posedge sclk) disable iff (!arst_n_i)
        issue_o |-> (link_state_i != dllp_pkg::INACTIVE))
        else $error("DLLP issued while link is inactive");

    a_wait_cnt_range : assert property (@(posedge sclk) disable iff (!arst_n_i)
        wait_cnt_q <= CNT_W'(`DLLP_RESEND_CYCLES))
        else $error("Resend counter out of range");

endmodule

//--- fc_credit_if.sv
`timescale 1ns/1ps

// Consumed-credit values from the transaction layer
interface fc_credit_if;

    dllp_pkg::fc_hdr_t  p_hdr;
    dllp_pkg::fc_hdr_t  np_hdr;
    dllp_pkg::fc_hdr_t  cpl_hdr;
    dllp_pkg::fc_data_t p_data;
    dllp_pkg::fc_data_t np_data;
    dllp_pkg::fc_data_t cpl_data;

    modport src (
        output p_hdr, np_hdr, cpl_hdr,
        output p_data, np_data, cpl_data
    );

    modport dst (
        input p_hdr, np_hdr, cpl_hdr,
        input p_data, np_data, cpl_data
    );

endinterface

//--- filelist.f
+incdir+.
dllp_pkg.sv
fc_credit_if.sv
dllp_sched_ctrl.sv
dllp_builder.sv
dllp_crc16.sv
dllp_framer.sv
dllp_gen_top.sv
tb_dllp_gen.sv

//--- tb_dllp_gen.sv
`timescale 1ns/1ps
`include "dllp_macros.svh"

module tb_dllp_gen;

    localparam int CLK_NS       = 8;
    localparam int RESEND       = `DLLP_RESEND_CYCLES;
    localparam int INIT_BUDGET  = 2 * (3 + RESEND) + 10;
    localparam int ACT_BUDGET   = 3 * (4 + RESEND) + 10;
    localparam int T6_BUDGET    = (4 + RESEND) + 10 + (4 + RESEND - 2) + 4 + RESEND + 10;
    localparam int TOTAL_CYCLES = 5 + 20 + 2 * INIT_BUDGET + 2 * ACT_BUDGET + T6_BUDGET + 100;

    logic                  sclk = 1'b0;
    logic                  arst_n_i;
    dllp_pkg::link_state_e link_state;
    dllp_pkg::fc_hdr_t     cc_p_h;
    dllp_pkg::fc_hdr_t     cc_np_h;
    dllp_pkg::fc_hdr_t     cc_cpl_h;
    dllp_pkg::fc_data_t    cc_p_d;
    dllp_pkg::fc_data_t    cc_np_d;
    dllp_pkg::fc_data_t    cc_cpl_d;
    logic                  nak_scheduled;
    dllp_pkg::seq_num_t    next_rcv_seq;
    logic                  init1_sent;
    logic                  init2_sent;
    logic                  dllp_valid;
    dllp_pkg::pipe_data_t  dllp_data;

    dllp_pkg::dllp_type_e  exp_order [4];
    int                    order_len;
    int                    beat_idx;
    bit                    init1_cpl_seen;
    bit                    init2_cpl_seen;
    bit                    chk_init1_low;
    bit                    chk_init2_low;
    int                    err_cnt;
    int                    test_err_base;
    int                    tests_run;
    int                    tests_failed;
    dllp_pkg::dllp_type_e  exp_type;
    dllp_pkg::pipe_data_t  exp_word;

    always #(CLK_NS / 2) sclk = ~sclk;

    dllp_gen_top dut_i (
        .sclk            (sclk),
        .arst_n_i        (arst_n_i),
        .link_state_i    (link_state),
        .cc_p_h_i        (cc_p_h),
        .cc_np_h_i       (cc_np_h),
        .cc_cpl_h_i      (cc_cpl_h),
        .cc_p_d_i        (cc_p_d),
        .cc_np_d_i       (cc_np_d),
        .cc_cpl_d_i      (cc_cpl_d),
        .nak_scheduled_i (nak_scheduled),
        .next_rcv_seq_i  (next_rcv_seq),
        .init1_sent_o    (init1_sent),
        .init2_sent_o    (init2_sent),
        .dllp_valid_o    (dllp_valid),
        .dllp_data_o     (dllp_data)
    );

    // Serial CRC over body bits 31 down to 0 and sent inverted
    function automatic dllp_pkg::dllp_crc_t calc_crc16(input dllp_pkg::dllp_body_t body);
        logic [15:0] crc;
        logic        fb;
        crc = `CRC_SEED;
        for (int b = 31; b >= 0; b--) begin
            fb  = crc[15] ^ body[b];
            crc = crc << 1;
            if (fb)
                crc = crc ^ `CRC_POLY;
        end
        return ~crc;
    endfunction

    function automatic dllp_pkg::pipe_data_t expected_dllp(
        input dllp_pkg::dllp_type_e t,
        input dllp_pkg::fc_hdr_t    ph,
        input dllp_pkg::fc_hdr_t    nph,
        input dllp_pkg::fc_hdr_t    cplh,
        input dllp_pkg::fc_data_t   pd,
        input dllp_pkg::fc_data_t   npd,
        input dllp_pkg::fc_data_t   cpld,
        input dllp_pkg::seq_num_t   seq
    );
        logic [7:0]           hdr;
        logic [11:0]          dat;
        dllp_pkg::dllp_body_t body;
        dllp_pkg::pipe_data_t word;
        hdr = 8'd0;
        dat = 12'd0;
        case (t)
            dllp_pkg::INITFC1_P, dllp_pkg::INITFC2_P: begin
                hdr = `CL_P_HDR;
                dat = `CL_P_DATA;
            end
            dllp_pkg::INITFC1_NP, dllp_pkg::INITFC2_NP: begin
                hdr = `CL_NP_HDR;
                dat = `CL_NP_DATA;
            end
            dllp_pkg::INITFC1_CPL, dllp_pkg::INITFC2_CPL: begin
                hdr = `CL_CPL_HDR;
                dat = `CL_CPL_DATA;
            end
            dllp_pkg::UPDATEFC_P: begin
                hdr = ph;
                dat = pd;
            end
            dllp_pkg::UPDATEFC_NP: begin
                hdr = nph;
                dat = npd;
            end
            dllp_pkg::UPDATEFC_CPL: begin
                hdr = cplh;
                dat = cpld;
            end
            default: ;
        endcase
        if (t == dllp_pkg::ACK || t == dllp_pkg::NAK)
            body = {8'(t), 12'd0, seq};
        else
            body = {8'(t), 2'b00, hdr, 2'b00, dat};
        word        = '0;
        word[15:0]  = `SDP_TOKEN;
        word[47:16] = body;
        word[63:48] = calc_crc16(body);
        return word;
    endfunction

    // Compares every beat and the flags on the falling edge
    always @(negedge sclk) begin
        if (arst_n_i) begin
            if (dllp_valid) begin
                if (order_len == 0) begin
                    $display("Unexpected DLLP beat at %0t ns while none was due", $time);
                    err_cnt++;
                end else begin
                    exp_type = exp_order[beat_idx % order_len];
                    exp_word = expected_dllp(exp_type, cc_p_h, cc_np_h, cc_cpl_h,
                                             cc_p_d, cc_np_d, cc_cpl_d, next_rcv_seq);
                    if (dllp_data !== exp_word) begin
                        $display("Error: %0t ns: beat %0d type %h got %h expected %h",
                                 $time, beat_idx, 8'(exp_type), dllp_data[63:0],
                                 exp_word[63:0]);
                        err_cnt++;
                    end
                    if (exp_type == dllp_pkg::INITFC1_CPL)
                        init1_cpl_seen = 1'b1;
                    if (exp_type == dllp_pkg::INITFC2_CPL)
                        init2_cpl_seen = 1'b1;
                    beat_idx++;
                end
            end else if (dllp_data !== '0) begin
                $display("Error: %0t ns: idle PIPE data not zero", $time);
                err_cnt++;
            end
            if ((init1_cpl_seen && init1_sent !== 1'b1) ||
                (chk_init1_low && init1_sent !== 1'b0)) begin
                $display("Error: %0t ns: init1_sent_o is %b", $time, init1_sent);
                err_cnt++;
            end
            if ((init2_cpl_seen && init2_sent !== 1'b1) ||
                (chk_init2_low && init2_sent !== 1'b0)) begin
                $display("Error: %0t ns: init2_sent_o is %b", $time, init2_sent);
                err_cnt++;
            end
        end
    end

    task automatic set_order(input dllp_pkg::dllp_type_e t0, input dllp_pkg::dllp_type_e t1,
                             input dllp_pkg::dllp_type_e t2, input dllp_pkg::dllp_type_e t3,
                             input int len);
        exp_order[0]   = t0;
        exp_order[1]   = t1;
        exp_order[2]   = t2;
        exp_order[3]   = t3;
        order_len      = len;
        beat_idx       = 0;
        init1_cpl_seen = 1'b0;
        init2_cpl_seen = 1'b0;
    endtask

    task automatic randomize_credits();
        cc_p_h       <= dllp_pkg::fc_hdr_t'($urandom());
        cc_np_h      <= dllp_pkg::fc_hdr_t'($urandom());
        cc_cpl_h     <= dllp_pkg::fc_hdr_t'($urandom());
        cc_p_d       <= dllp_pkg::fc_data_t'($urandom());
        cc_np_d      <= dllp_pkg::fc_data_t'($urandom());
        cc_cpl_d     <= dllp_pkg::fc_data_t'($urandom());
        next_rcv_seq <= dllp_pkg::seq_num_t'($urandom());
    endtask

    task automatic wait_beats(input int n, input int budget);
        int cyc;
        cyc = 0;
        while (beat_idx < n && cyc < budget) begin
            @(posedge sclk);
            cyc++;
        end
        if (beat_idx < n) begin
            $display("Missing DLLP beats: only %0d of %0d arrived within %0d cycles",
                     beat_idx, n, budget);
            err_cnt++;
        end
    endtask

    task automatic begin_test();
        test_err_base = err_cnt;
        tests_run++;
    endtask

    task automatic end_test(input string name);
        if (err_cnt == test_err_base) begin
            $display("Test %0d %s: passed", tests_run, name);
        end else begin
            $display("Test %0d %s: failed with %0d errors", tests_run, name,
                     err_cnt - test_err_base);
            tests_failed++;
        end
    endtask

    initial begin
        #(TOTAL_CYCLES * CLK_NS);
        $display("Watchdog expired after %0d cycles, the run did not complete", TOTAL_CYCLES);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        int b0;
        void'($urandom(32'hed9));
        err_cnt      = 0;
        tests_run    = 0;
        tests_failed = 0;
        set_order(dllp_pkg::ACK, dllp_pkg::ACK, dllp_pkg::ACK, dllp_pkg::ACK, 0);
        chk_init1_low  = 1'b1;
        chk_init2_low  = 1'b1;
        arst_n_i      <= 1'b0;
        link_state    <= dllp_pkg::INACTIVE;
        nak_scheduled <= 1'b0;
        cc_p_h        <= '0;
        cc_np_h       <= '0;
        cc_cpl_h      <= '0;
        cc_p_d        <= '0;
        cc_np_d       <= '0;
        cc_cpl_d      <= '0;
        next_rcv_seq  <= '0;
        repeat (3) @(posedge sclk);
        arst_n_i <= 1'b1;

        begin_test();
        repeat (20) @(posedge sclk);   // Checker flags any beat or flag
        end_test("idle after reset");

        begin_test();
        @(posedge sclk);
        link_state <= dllp_pkg::INIT1;
        set_order(dllp_pkg::INITFC1_P, dllp_pkg::INITFC1_NP, dllp_pkg::INITFC1_CPL,
                  dllp_pkg::INITFC1_CPL, 3);
        chk_init1_low = 1'b0;
        wait_beats(6, INIT_BUDGET);
        end_test("InitFC1 rounds");

        begin_test();
        @(posedge sclk);
        link_state <= dllp_pkg::INIT2;
        set_order(dllp_pkg::INITFC2_P, dllp_pkg::INITFC2_NP, dllp_pkg::INITFC2_CPL,
                  dllp_pkg::INITFC2_CPL, 3);
        chk_init2_low = 1'b0;
        @(posedge sclk);
        chk_init1_low = 1'b1;           // init1 flag has cleared by now
        wait_beats(6, INIT_BUDGET);
        end_test("InitFC2 rounds");

        begin_test();
        @(posedge sclk);
        link_state <= dllp_pkg::ACTIVE;
        randomize_credits();
        set_order(dllp_pkg::UPDATEFC_P, dllp_pkg::UPDATEFC_NP, dllp_pkg::UPDATEFC_CPL,
                  dllp_pkg::ACK, 4);
        @(posedge sclk);
        chk_init2_low = 1'b1;
        wait_beats(8, ACT_BUDGET);
        end_test("UpdateFC with Ack");

        begin_test();
        @(posedge sclk);
        nak_scheduled <= 1'b1;
        randomize_credits();
        set_order(dllp_pkg::UPDATEFC_P, dllp_pkg::UPDATEFC_NP, dllp_pkg::UPDATEFC_CPL,
                  dllp_pkg::NAK, 4);
        wait_beats(8, ACT_BUDGET);
        end_test("UpdateFC with Nak");

        begin_test();
        set_order(dllp_pkg::UPDATEFC_P, dllp_pkg::UPDATEFC_NP, dllp_pkg::UPDATEFC_CPL,
                  dllp_pkg::NAK, 4);
        wait_beats(1, 4 + RESEND + 10);
        // Land inside the next round two issues after its start
        repeat (4 + RESEND - 2) @(posedge sclk);
        link_state <= dllp_pkg::INACTIVE;
        b0 = beat_idx;
        repeat (4) @(posedge sclk);
        if (beat_idx - b0 > 3) begin
            $display("Too many DLLP beats after the link went inactive: %0d", beat_idx - b0);
            err_cnt++;
        end else if (beat_idx == b0) begin
            $display("No DLLP of the interrupted round drained out");
            err_cnt++;
        end
        order_len = 0;                  // No beat may follow now
        repeat (RESEND + 10) @(posedge sclk);
        end_test("return to inactive mid-round");

        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, err_cnt);
        if (err_cnt == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
